// ==== Bender.yml ====
package:
  name: vbw

sources:
  - vbw_pkg.sv
  - vbw_operand_stage.sv
  - vbw_bw_or.sv
  - vbw_bw_and.sv
  - vbw_logic_alu.sv
  - vbw_result_stage.sv
  - vbw_top.sv
  - target: simulation
    files:
      - vbw_checker.sv
      - vbw_tb.sv

// ==== sim.f ====
vbw_pkg.sv
vbw_operand_stage.sv
vbw_bw_or.sv
vbw_bw_and.sv
vbw_logic_alu.sv
vbw_result_stage.sv
vbw_top.sv
vbw_checker.sv
vbw_tb.sv

// ==== vbw_bw_and.sv ====
/*
 * AND lane array
 * Byte AND cells chained like the OR array, all ones as neutral value
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_bw_and
    import vbw_pkg::*;
(
    input  logic                     is_reduct,
    input  logic                     is_and,
    input  logic [VBW_NUM_BYTES-1:0] byte_valid,
    input  logic [VBW_LOG_BYTES-1:0] osize_vector,
    input  logic [VBW_LOG_BYTES:0]   greater_osize_vector,
    input  vbw_byte_vec_t            srca,
    input  vbw_byte_vec_t            srcb,
    output vbw_byte_vec_t            result
);

    logic [VBW_BYTE_W-1:0]    srca_gated [VBW_NUM_BYTES];
    logic [VBW_BYTE_W-1:0]    srca_bw    [VBW_NUM_BYTES];
    logic [VBW_BYTE_W-1:0]    srcb_bw    [VBW_NUM_BYTES];
    logic [VBW_BYTE_W-1:0]    result_bw  [VBW_NUM_BYTES];
    // Element size in bytes as a one-hot stride
    logic [VBW_LOG_BYTES-1:0] stride_sel;

    assign stride_sel = greater_osize_vector[VBW_LOG_BYTES-1:0] & ~osize_vector;

    for (genvar b = 0; b < VBW_NUM_BYTES; b++) begin : gen_gate
        assign srca_gated[b] = srca[b] & {VBW_BYTE_W{is_and}};
        // Inactive srcb bytes become all ones, then the op gate applies
        assign srcb_bw[b]    = (srcb[b] | {VBW_BYTE_W{~byte_valid[b]}})
                             & {VBW_BYTE_W{is_and}};
    end

    assign srca_bw[0] = srca_gated[0];

    for (genvar b = 1; b < VBW_NUM_BYTES; b++) begin : gen_chain
        always_comb begin
            // Outside element 0 a reduction starts from all ones
            srca_bw[b] = srca_gated[b]
                       | {VBW_BYTE_W{is_reduct & ~greater_osize_vector[$clog2(b + 1)]}};
            // Previous element lane, passes ones when not selected
            for (int r = 0; r < $clog2(b + 1); r++) begin
                srca_bw[b] &= result_bw[b - (2 ** r)]
                            | {VBW_BYTE_W{~(is_reduct & stride_sel[r])}};
            end
        end
    end

    // Byte-wide AND cells
    for (genvar b = 0; b < VBW_NUM_BYTES; b++) begin : gen_and_cell
        assign result_bw[b] = srca_bw[b] & srcb_bw[b];
        assign result[b]    = result_bw[b];
    end

endmodule

`default_nettype wire

// ==== vbw_bw_or.sv ====
/*
 * OR lane array
 * One byte OR cell per lane, lanes chained by element stride for reductions
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_bw_or
    import vbw_pkg::*;
(
    input  logic                     is_reduct,
    input  logic                     is_or,
    input  logic [VBW_NUM_BYTES-1:0] byte_valid,
    input  logic [VBW_LOG_BYTES-1:0] osize_vector,
    input  logic [VBW_LOG_BYTES:0]   greater_osize_vector,
    input  vbw_byte_vec_t            srca,
    input  vbw_byte_vec_t            srcb,
    output vbw_byte_vec_t            result
);

    // Sources after the op gate
    logic [VBW_BYTE_W-1:0]    srca_gated [VBW_NUM_BYTES];
    // First operand of each cell, scalar byte or chained lane
    logic [VBW_BYTE_W-1:0]    srca_bw    [VBW_NUM_BYTES];
    // Second operand, cleared where srcb is inactive
    logic [VBW_BYTE_W-1:0]    srcb_bw    [VBW_NUM_BYTES];
    // Cell outputs
    logic [VBW_BYTE_W-1:0]    result_bw  [VBW_NUM_BYTES];
    // One-hot, stride 2**r equals the element size in bytes
    logic [VBW_LOG_BYTES-1:0] stride_sel;

    assign stride_sel = greater_osize_vector[VBW_LOG_BYTES-1:0] & ~osize_vector;

    for (genvar b = 0; b < VBW_NUM_BYTES; b++) begin : gen_gate
        assign srca_gated[b] = srca[b] & {VBW_BYTE_W{is_or}};
        // Zero is neutral, so dead bytes drop out of a fold
        assign srcb_bw[b]    = srcb[b] & {VBW_BYTE_W{is_or & byte_valid[b]}};
    end

    // Lane 0 only ever sees its own srca byte
    assign srca_bw[0] = srca_gated[0];

    for (genvar b = 1; b < VBW_NUM_BYTES; b++) begin : gen_chain
        always_comb begin
            // Keep srca when element-wise or when this byte lies in element 0
            srca_bw[b] = srca_gated[b]
                       & {VBW_BYTE_W{~is_reduct | greater_osize_vector[$clog2(b + 1)]}};
            // Fold in the same byte of the previous element
            for (int r = 0; r < $clog2(b + 1); r++) begin
                srca_bw[b] |= result_bw[b - (2 ** r)]
                            & {VBW_BYTE_W{is_reduct & stride_sel[r]}};
            end
        end
    end

    // Byte-wide OR cells
    for (genvar b = 0; b < VBW_NUM_BYTES; b++) begin : gen_or_cell
        assign result_bw[b] = srca_bw[b] | srcb_bw[b];
        assign result[b]    = result_bw[b];
    end

endmodule

`default_nettype wire

// ==== vbw_checker.sv ====
/*
 * Vector logic unit protocol checker
 * Strobe latency, quiet strobes in reset, known response data
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_checker
    import vbw_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  logic     lane_valid,
    input  logic     rsp_valid,
    input  vbw_rsp_t rsp
);

    // Failed assertion count, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // Each request is answered two edges later
    a_req_to_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> ##2 rsp_valid)
        else begin
            $error("rsp_valid missing two cycles after req_valid");
            fail_cnt++;
        end

    // No response without a request two edges before
    a_rsp_from_req: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> $past(req_valid, 2))
        else begin
            $error("rsp_valid without a request two cycles earlier");
            fail_cnt++;
        end

    // All strobes low while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !req_valid && !lane_valid && !rsp_valid)
        else begin
            $error("strobe high during reset");
            fail_cnt++;
        end

    a_rsp_known: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !$isunknown(rsp))
        else begin
            $error("unknown bits in rsp while rsp_valid");
            fail_cnt++;
        end

endmodule

// Attach to every vbw_top, internal lane strobe included
bind vbw_top vbw_checker vbw_checker_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .lane_valid (lane_valid),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
);

`default_nettype wire

// ==== vbw_logic_alu.sv ====
/*
 * Vector logic ALU
 * Runs the OR and AND arrays, derives XOR and selects by op code
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_logic_alu
    import vbw_pkg::*;
(
    input  vbw_lanes_t    lanes,
    output vbw_byte_vec_t alu_result
);

    logic                     is_xor;
    logic                     is_or;
    logic                     is_and;
    // Arrays chain only for OR and AND reductions
    logic                     array_reduct;
    vbw_byte_vec_t            or_result;
    vbw_byte_vec_t            and_result;
    // Per-lane two-operand XOR
    vbw_byte_vec_t            xor_pair;
    // XOR fold across elements
    logic [VBW_BYTE_W-1:0]    xor_fold [VBW_NUM_BYTES];
    logic [VBW_LOG_BYTES-1:0] stride_sel;

    assign is_xor       = lanes.op == VBW_XOR;
    // XOR needs both arrays on the same operands
    assign is_or        = (lanes.op == VBW_OR) | is_xor;
    assign is_and       = (lanes.op == VBW_AND) | is_xor;
    assign array_reduct = lanes.is_reduct & ~is_xor;
    assign stride_sel   = lanes.greater_osize_vector[VBW_LOG_BYTES-1:0] & ~lanes.osize_vector;

    vbw_bw_or vbw_bw_or_i (
        .is_reduct            (array_reduct),
        .is_or                (is_or),
        .byte_valid           (lanes.byte_valid),
        .osize_vector         (lanes.osize_vector),
        .greater_osize_vector (lanes.greater_osize_vector),
        .srca                 (lanes.srca),
        .srcb                 (lanes.srcb),
        .result               (or_result)
    );

    vbw_bw_and vbw_bw_and_i (
        .is_reduct            (array_reduct),
        .is_and               (is_and),
        .byte_valid           (lanes.byte_valid),
        .osize_vector         (lanes.osize_vector),
        .greater_osize_vector (lanes.greater_osize_vector),
        .srca                 (lanes.srca),
        .srcb                 (lanes.srcb),
        .result               (and_result)
    );

    // a ^ b = (a | b) & ~(a & b), only for two operands per lane
    // Dead srcb bytes must pass srca, so the AND term is masked there
    for (genvar b = 0; b < VBW_NUM_BYTES; b++) begin : gen_xor_pair
        assign xor_pair[b] = or_result[b]
                           & ~(and_result[b] & {VBW_BYTE_W{lanes.byte_valid[b]}});
    end

    // Multi-operand XOR does not follow from OR and AND folds, ripple it here
    assign xor_fold[0] = xor_pair[0];

    for (genvar b = 1; b < VBW_NUM_BYTES; b++) begin : gen_xor_chain
        always_comb begin
            xor_fold[b] = xor_pair[b];
            for (int r = 0; r < $clog2(b + 1); r++) begin
                xor_fold[b] ^= xor_fold[b - (2 ** r)]
                             & {VBW_BYTE_W{lanes.is_reduct & stride_sel[r]}};
            end
        end
    end

    always_comb begin
        alu_result = '0;
        case (lanes.op)
            VBW_AND: alu_result = and_result;
            VBW_OR:  alu_result = or_result;
            VBW_XOR: begin
                for (int b = 0; b < VBW_NUM_BYTES; b++) begin
                    alu_result[b] = xor_fold[b];
                end
            end
            default: alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== vbw_operand_stage.sv ====
/*
 * Vector logic unit input stage
 * Decodes element size and vl into byte lanes and registers the operands
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_operand_stage
    import vbw_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  vbw_req_t   req,
    output logic       lane_valid,
    output vbw_lanes_t lanes
);

    // Bytes per element, 1 to 8
    logic [VBW_LOG_BYTES:0] elem_bytes;
    // Next value of the lane register
    vbw_lanes_t             lanes_d;

    assign elem_bytes = {{VBW_LOG_BYTES{1'b0}}, 1'b1} << req.esize;

    always_comb begin
        lanes_d           = '0;
        lanes_d.op        = req.op;
        lanes_d.is_reduct = req.is_reduct;
        lanes_d.esize     = req.esize;
        lanes_d.srcb      = req.srcb;
        // Byte b belongs to element b >> esize
        for (int b = 0; b < VBW_NUM_BYTES; b++) begin
            lanes_d.byte_valid[b] = ({1'b0, VBW_LOG_BYTES'(b)} >> req.esize) < req.vl;
        end
        // Thermometer, strictly larger than 2**r bytes
        for (int r = 0; r < VBW_LOG_BYTES; r++) begin
            lanes_d.osize_vector[r] = int'(req.esize) > r;
        end
        // At least 2**k bytes
        for (int k = 0; k <= VBW_LOG_BYTES; k++) begin
            lanes_d.greater_osize_vector[k] = int'(req.esize) >= k;
        end
        // Reduction scalar is element 0 of srca only
        // Remaining bytes take the neutral value of the op
        for (int b = 0; b < VBW_NUM_BYTES; b++) begin
            if (req.is_reduct && (b >= elem_bytes)) begin
                lanes_d.srca[b] = (req.op == VBW_AND) ? '1 : '0;
            end else begin
                lanes_d.srca[b] = req.srca[b];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_valid <= 1'b0;
            lanes      <= '0;
        end else begin
            lane_valid <= req_valid;
            // Operands only move on a strobe
            if (req_valid) begin
                lanes <= lanes_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vbw_pkg.sv ====
/*
 * Vector logic unit shared definitions
 * Lane geometry, operation and element-size codes, request and response words
 */
`default_nettype none

package vbw_pkg;

    // Datapath geometry, 8 byte lanes of 8 bits
    localparam int VBW_NUM_BYTES = 8;
    localparam int VBW_BYTE_W    = 8;
    // Sizes the element-size vectors
    localparam int VBW_LOG_BYTES = 3;

    // Operation code
    typedef enum logic [1:0] {
        VBW_AND = 2'd0,
        VBW_OR  = 2'd1,
        VBW_XOR = 2'd2
    } vbw_op_e;

    // Element size as log2 of bytes per element
    typedef enum logic [1:0] {
        VBW_E8  = 2'd0,
        VBW_E16 = 2'd1,
        VBW_E32 = 2'd2,
        VBW_E64 = 2'd3
    } vbw_esize_e;

    // One 64-bit vector register seen as bytes
    typedef logic [VBW_NUM_BYTES-1:0][VBW_BYTE_W-1:0] vbw_byte_vec_t;

    // Request as issued by the vector pipeline
    typedef struct packed {
        vbw_op_e       op;
        logic          is_reduct;
        vbw_esize_e    esize;
        logic [3:0]    vl;           // Active element count
        vbw_byte_vec_t srca;
        vbw_byte_vec_t srcb;
    } vbw_req_t;

    // Decoded operands handed to the lane arrays
    typedef struct packed {
        vbw_op_e                  op;
        logic                     is_reduct;
        vbw_esize_e               esize;
        logic [VBW_NUM_BYTES-1:0] byte_valid;
        // Bit r set when an element spans more than 2**r bytes
        logic [VBW_LOG_BYTES-1:0] osize_vector;
        // Bit k set when an element spans at least 2**k bytes
        logic [VBW_LOG_BYTES:0]   greater_osize_vector;
        vbw_byte_vec_t            srca;
        vbw_byte_vec_t            srcb;
    } vbw_lanes_t;

    // Response word
    typedef struct packed {
        vbw_byte_vec_t result;
        logic          is_reduct;
    } vbw_rsp_t;

endpackage

`default_nettype wire

// ==== vbw_result_stage.sv ====
/*
 * Vector logic unit output stage
 * Moves the reduction fold to element 0, clears dead bytes, registers response
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_result_stage
    import vbw_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          lane_valid,
    input  vbw_lanes_t    lanes,
    input  vbw_byte_vec_t alu_result,
    output logic          rsp_valid,
    output vbw_rsp_t      rsp
);

    // Highest active byte, lane 0 when vl is zero
    logic [VBW_LOG_BYTES-1:0] top_byte;
    // First byte of the highest active element
    logic [VBW_LOG_BYTES-1:0] top_base;
    logic [VBW_LOG_BYTES:0]   elem_bytes;
    vbw_byte_vec_t            result_d;

    assign elem_bytes = {{VBW_LOG_BYTES{1'b0}}, 1'b1} << lanes.esize;
    assign top_base   = top_byte & ~VBW_LOG_BYTES'(elem_bytes - 1'b1);

    always_comb begin
        top_byte = '0;
        for (int b = 0; b < VBW_NUM_BYTES; b++) begin
            if (lanes.byte_valid[b]) begin
                top_byte = VBW_LOG_BYTES'(b);
            end
        end
    end

    always_comb begin
        result_d = '0;
        for (int b = 0; b < VBW_NUM_BYTES; b++) begin
            if (lanes.is_reduct) begin
                // The top element holds the complete fold
                if (b < elem_bytes) begin
                    result_d[b] = alu_result[top_base + VBW_LOG_BYTES'(b)];
                end
            end else if (lanes.byte_valid[b]) begin
                result_d[b] = alu_result[b];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= lane_valid;
            if (lane_valid) begin
                rsp.result    <= result_d;
                rsp.is_reduct <= lanes.is_reduct;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vbw_tb.sv ====
/*
 * Vector logic unit testbench
 * LFSR operands, reference model, in-order response compare
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_tb
    import vbw_pkg::*;
();

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    vbw_req_t req;
    logic     rsp_valid;
    vbw_rsp_t rsp;

    logic [15:0] lfsr_q;
    int          cyc = 0;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;
    int          test_err0;
    // Expected responses and their issue cycles in order
    vbw_rsp_t    exp_q[$];
    int          cyc_q[$];

    vbw_top vbw_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[62:0], lfsr_q[0]};
        end
    endtask

    task automatic draw_below(input int n, output int v);
        logic [63:0] raw;
        draw(8, raw);
        v = int'(raw) % n;
    endtask

    // Expected response from the element rules
    function automatic vbw_rsp_t ref_vbw(input vbw_req_t r);
        vbw_rsp_t    exp_rsp;
        int          nbytes;
        int          nelem;
        logic [63:0] emask;
        logic [63:0] a_el;
        logic [63:0] b_el;
        logic [63:0] acc;
        logic [63:0] res;
        nbytes = 1 << int'(r.esize);
        nelem  = 8 / nbytes;
        emask  = (nbytes == 8) ? '1 : ((64'd1 << (nbytes * 8)) - 64'd1);
        res    = '0;
        // Scalar is element 0 of srca
        acc    = r.srca & emask;
        for (int e = 0; e < nelem; e++) begin
            if (e < int'(r.vl)) begin
                a_el = (r.srca >> (e * nbytes * 8)) & emask;
                b_el = (r.srcb >> (e * nbytes * 8)) & emask;
                if (r.is_reduct) begin
                    case (r.op)
                        VBW_AND: acc = acc & b_el;
                        VBW_OR:  acc = acc | b_el;
                        default: acc = acc ^ b_el;
                    endcase
                end else begin
                    case (r.op)
                        VBW_AND: res |= (a_el & b_el) << (e * nbytes * 8);
                        VBW_OR:  res |= (a_el | b_el) << (e * nbytes * 8);
                        default: res |= (a_el ^ b_el) << (e * nbytes * 8);
                    endcase
                end
            end
        end
        if (r.is_reduct) begin
            res = acc;
        end
        exp_rsp.result    = res;
        exp_rsp.is_reduct = r.is_reduct;
        return exp_rsp;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic make_req(input int op, input bit red, input int es, input int vl,
                            output vbw_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        draw(64, a);
        draw(64, b);
        r.op        = vbw_op_e'(op);
        r.is_reduct = red;
        r.esize     = vbw_esize_e'(es);
        r.vl        = 4'(vl);
        r.srca      = a;
        r.srcb      = b;
    endtask

    // Drive on the falling edge and queue the expectation
    task automatic issue(input vbw_req_t r);
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(ref_vbw(r));
        cyc_q.push_back(cyc);
    endtask

    task automatic end_test(input int num, input string name);
        int waited;
        @(negedge clk);
        req_valid = 1'b0;
        waited    = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in test %0d, %0d responses never came", num, exp_q.size());
            errors++;
            exp_q.delete();
            cyc_q.delete();
        end
        tests++;
        if (errors != test_err0) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", num, name, (errors == test_err0) ? "ok" : "errors");
        test_err0 = errors;
    endtask

    // Responses sampled mid-cycle away from the rising edge
    always @(negedge clk) begin : compare_rsp
        vbw_rsp_t exp_rsp;
        int       issued;
        if (arst_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no request outstanding");
                errors++;
            end else begin
                exp_rsp = exp_q.pop_front();
                issued  = cyc_q.pop_front();
                check_val("rsp.result", rsp.result, exp_rsp.result);
                check_val("rsp.is_reduct", 64'(rsp.is_reduct), 64'(exp_rsp.is_reduct));
                check_val("latency", 64'(cyc - issued), 64'd2);
            end
        end
    end

    initial begin : stimulus
        vbw_req_t r;
        int       v;
        int       op;
        int       es;
        logic [63:0] raw;
        clk = 1'b0;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        lfsr_q = 16'd521;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        test_err0 = 0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        // Quiet output until the first request
        repeat (12) begin
            @(negedge clk);
            check_val("rsp_valid", 64'(rsp_valid), 64'd0);
        end
        end_test(1, "after reset");

        for (int o = 0; o < 3; o++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (3) begin
                    make_req(o, 1'b0, s, 8 >> s, r);
                    issue(r);
                end
            end
        end
        end_test(2, "element-wise full vl");

        // vl below the element count with zero included
        for (int o = 0; o < 3; o++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (2) begin
                    draw_below(8 >> s, v);
                    make_req(o, 1'b0, s, v, r);
                    issue(r);
                end
            end
        end
        end_test(3, "partial vl");

        for (int o = 0; o < 3; o++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (4) begin
                    draw_below(8 >> s, v);
                    make_req(o, 1'b1, s, v + 1, r);
                    issue(r);
                end
            end
        end
        end_test(4, "reductions");

        // One request per cycle with all ops mixed
        repeat (200) begin
            draw_below(3, op);
            draw(2, raw);
            es = int'(raw);
            draw_below((8 >> es) + 1, v);
            draw(1, raw);
            make_req(op, raw[0], es, v, r);
            issue(r);
        end
        end_test(5, "back-to-back streaming");

        errors += int'(vbw_top_i.vbw_checker_i.fail_cnt);
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, checks, errors, vbw_top_i.vbw_checker_i.fail_cnt);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vbw_top.sv ====
/*
 * Vector logic unit top level
 * Operand register, combinational ALU, result register, 2 cycles latency
 */
`timescale 1ns/1ns
`default_nettype none

module vbw_top
    import vbw_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  vbw_req_t req,
    output logic     rsp_valid,
    output vbw_rsp_t rsp
);

    // Between input stage and ALU
    logic          lane_valid;
    vbw_lanes_t    lanes;
    // ALU output, same cycle as lanes
    vbw_byte_vec_t alu_result;

    vbw_operand_stage vbw_operand_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .lane_valid (lane_valid),
        .lanes      (lanes)
    );

    vbw_logic_alu vbw_logic_alu_i (
        .lanes      (lanes),
        .alu_result (alu_result)
    );

    vbw_result_stage vbw_result_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .lane_valid (lane_valid),
        .lanes      (lanes),
        .alu_result (alu_result),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire
